/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_hispi_lane_rx
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hispi_lane_regs.sv */
`timescale 1ns/1ps

module hispi_lane_regs #(
    parameter int COUNT_START = 7                // lines up to this long are short
) (
    input  logic                   ipclk,
    input  logic                   prst,
    input  logic                   cfg_we,
    input  hispi_pkg::reg_addr_t   cfg_addr,
    input  hispi_pkg::reg_data_t   cfg_wdata,
    output hispi_pkg::reg_data_t   cfg_rdata,    // combinational read
    input  hispi_pkg::hispi_word_t word_out,     // decoder output, observed only
    output logic                   enable
);

    localparam logic [15:0] SHORT_MAX = 16'(COUNT_START);

    hispi_pkg::reg_data_t lines_cnt;
    hispi_pkg::reg_data_t short_cnt;
    logic [15:0]          word_cnt;              // words so far in current line
    logic [15:0]          line_words;            // includes word under eol

    assign line_words = word_cnt + 16'(word_out.we);

    always_ff @(posedge ipclk) begin
        if (prst) begin
            enable    <= 1'b0;
            lines_cnt <= '0;
            short_cnt <= '0;
            word_cnt  <= '0;
        end else begin
            if (cfg_we && (cfg_addr == hispi_pkg::REG_CTRL))
                enable <= cfg_wdata[hispi_pkg::CTRL_EN_BIT];

            if (word_out.sol)
                word_cnt <= '0;                  // new line
            else if (word_out.we && (word_cnt != 16'hFFFE))
                word_cnt <= word_cnt + 16'd1;    // saturate

            // counter write clears, wins over a same-cycle eol
            if (cfg_we && (cfg_addr == hispi_pkg::REG_LINES))
                lines_cnt <= '0;
            else if (word_out.eol)
                lines_cnt <= lines_cnt + 16'd1;

            if (cfg_we && (cfg_addr == hispi_pkg::REG_SHORT))
                short_cnt <= '0;
            else if (word_out.eol && (line_words <= SHORT_MAX))
                short_cnt <= short_cnt + 16'd1;  // run never started for it
        end
    end

    always_comb begin
        case (cfg_addr)
            hispi_pkg::REG_CTRL:  cfg_rdata = {15'd0, enable};
            hispi_pkg::REG_LINES: cfg_rdata = lines_cnt;
            hispi_pkg::REG_SHORT: cfg_rdata = short_cnt;
            default:              cfg_rdata = '0;
        endcase
    end

endmodule

/* hispi_lane_rx.sv */
`timescale 1ns/1ps

module hispi_lane_rx #(
    parameter int COUNT_START = 7,               // run starts after this many + 1
    parameter int FIFO_DEPTH  = 4                // log2 of line buffer
) (
    input  logic                 ipclk,
    input  logic                 prst,
    input  hispi_pkg::pixel_t    rx_word,
    input  logic                 rx_valid,
    input  logic                 cfg_we,
    input  hispi_pkg::reg_addr_t cfg_addr,
    input  hispi_pkg::reg_data_t cfg_wdata,
    output hispi_pkg::reg_data_t cfg_rdata,
    input  logic                 pclk,
    input  logic                 re,
    output hispi_pkg::pixel_t    dout,
    output logic                 run
);

    hispi_pkg::hispi_word_t word_out;            // tagged payload
    logic                   enable;

    hispi_sync_decoder u_dec (
        .ipclk    (ipclk),
        .prst     (prst),
        .enable   (enable),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .word_out (word_out)
    );

    hispi_lane_regs #(
        .COUNT_START (COUNT_START)
    ) u_regs (
        .ipclk     (ipclk),
        .prst      (prst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .word_out  (word_out),
        .enable    (enable)
    );

    sens_hispi_fifo #(
        .COUNT_START (COUNT_START),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .data_t      (hispi_pkg::pixel_t)
    ) u_fifo (
        .ipclk (ipclk),
        .prst  (prst),
        .we    (word_out.we),
        .sol   (word_out.sol),
        .eol   (word_out.eol),
        .din   (word_out.data),
        .pclk  (pclk),
        .re    (re),
        .dout  (dout),
        .run   (run)
    );

endmodule

/* hispi_lane_rx_sva.sv */
`timescale 1ns/1ps

module hispi_lane_rx_sva (
    input logic                   ipclk,
    input logic                   pclk,
    input logic                   prst,
    input logic                   prst_pclk,     // reset as seen by the read side
    input logic                   enable,
    input hispi_pkg::hispi_word_t word_out,
    input logic                   run
);

    int fail_cnt = 0;                            // failed assertions so far

    // a line opens and closes in different cycles
    sol_eol_apart: assert property (@(posedge ipclk) disable iff (prst)
        !(word_out.sol && word_out.eol))
        else begin
            $error("sol and eol in the same ipclk cycle");
            fail_cnt++;
        end

    run_low_in_reset: assert property (@(posedge pclk)
        prst_pclk |=> !run)
        else begin
            $error("run high while the pclk reset is active");
            fail_cnt++;
        end

    // a line in flight is dropped, nothing left in the pipe
    no_write_when_off: assert property (@(posedge ipclk)
        !enable |=> !word_out.we)
        else begin
            $error("payload write while the lane is disabled");
            fail_cnt++;
        end

endmodule

bind hispi_lane_rx hispi_lane_rx_sva u_sva (
    .ipclk     (ipclk),
    .pclk      (pclk),
    .prst      (prst),
    .prst_pclk (u_fifo.prst_sync[1]),
    .enable    (enable),
    .word_out  (word_out),
    .run       (run)
);

/* hispi_pkg.sv */
package hispi_pkg;

    typedef logic [11:0] pixel_t;                 // one deserialized sensor word

    // decoder output, one word per ipclk
    typedef struct packed {
        logic   we;                               // payload word valid
        logic   sol;                              // start of line, ahead of first we
        logic   eol;                              // end of line, with last we
        pixel_t data;
    } hispi_word_t;

    // sync sequence: FFF 000 000 code
    localparam pixel_t SYNC_PREFIX = 12'hFFF;     // reserved, never in payload
    localparam pixel_t SYNC_ZERO   = 12'h000;

    localparam pixel_t CODE_SOL = 12'h800;        // start of line
    localparam pixel_t CODE_SOF = 12'hC00;        // start of frame, also opens a line
    localparam pixel_t CODE_EOL = 12'hA00;        // end of line
    localparam pixel_t CODE_EOF = 12'hE00;        // end of frame, also closes a line

    // config bus
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    localparam reg_addr_t REG_CTRL  = 2'd0;       // bit 0 lane enable
    localparam reg_addr_t REG_LINES = 2'd1;       // complete lines seen
    localparam reg_addr_t REG_SHORT = 2'd2;       // lines too short to start run

    localparam int CTRL_EN_BIT = 0;

    // sync code classes
    function automatic logic is_start_code(input pixel_t code);
        return (code == CODE_SOL) || (code == CODE_SOF);
    endfunction

    function automatic logic is_end_code(input pixel_t code);
        return (code == CODE_EOL) || (code == CODE_EOF);
    endfunction

endpackage

/* hispi_sync_decoder.sv */
`timescale 1ns/1ps

module hispi_sync_decoder (
    input  logic                   ipclk,
    input  logic                   prst,
    input  logic                   enable,       // lane enable from regs
    input  hispi_pkg::pixel_t      rx_word,
    input  logic                   rx_valid,
    output hispi_pkg::hispi_word_t word_out
);

    localparam int PIPE_LEN = 4;                 // plus output reg = five stages

    hispi_pkg::pixel_t   hist [3];               // last accepted words, [0] newest
    hispi_pkg::pixel_t   pipe_data [PIPE_LEN];
    logic [PIPE_LEN-1:0] pipe_vld;               // payload tag per stage
    logic                line_act;               // between start and end code
    logic                out_we;
    logic                out_sol;
    logic                out_eol;
    hispi_pkg::pixel_t   out_data;
    logic                in_sync;
    logic                sync_hit;
    logic                start_hit;
    logic                end_hit;

    // payload never holds FFF, so an FFF anywhere in the window
    // means the current word is part of a sync sequence
    assign in_sync = (rx_word == hispi_pkg::SYNC_PREFIX) ||
                     (hist[0] == hispi_pkg::SYNC_PREFIX) ||
                     (hist[1] == hispi_pkg::SYNC_PREFIX) ||
                     (hist[2] == hispi_pkg::SYNC_PREFIX);

    assign sync_hit  = rx_valid &&
                       (hist[2] == hispi_pkg::SYNC_PREFIX) &&
                       (hist[1] == hispi_pkg::SYNC_ZERO) &&
                       (hist[0] == hispi_pkg::SYNC_ZERO);    // rx_word is the code
    assign start_hit = sync_hit && hispi_pkg::is_start_code(rx_word);
    assign end_hit   = sync_hit && hispi_pkg::is_end_code(rx_word);

    // four-word compare window
    always_ff @(posedge ipclk) begin
        if (prst) begin
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
        end else if (rx_valid) begin
            hist[0] <= rx_word;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
        end
    end

    // line tracking and stage tags, disable drops the line
    always_ff @(posedge ipclk) begin
        if (prst || !enable) begin
            pipe_vld <= '0;
            line_act <= 1'b0;
        end else begin
            pipe_vld <= {pipe_vld[PIPE_LEN-2:0], rx_valid && line_act && !in_sync};
            if (start_hit)
                line_act <= 1'b1;
            else if (end_hit)
                line_act <= 1'b0;
        end
    end

    // data shifts every cycle, fixed latency
    always_ff @(posedge ipclk) begin
        pipe_data[0] <= rx_word;
        for (int i = 1; i < PIPE_LEN; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    // fifth stage; end code lands while the last payload word is oldest
    always_ff @(posedge ipclk) begin
        if (prst) begin
            out_we   <= 1'b0;
            out_sol  <= 1'b0;
            out_eol  <= 1'b0;
            out_data <= '0;
        end else begin
            out_we   <= pipe_vld[PIPE_LEN-1] && enable;
            out_sol  <= start_hit && enable;                   // n+1 after code
            out_eol  <= end_hit && line_act && pipe_vld[PIPE_LEN-1] && enable;
            out_data <= pipe_data[PIPE_LEN-1];
        end
    end

    // strobes die at once when the lane is switched off
    always_comb begin
        word_out.we   = out_we & enable;
        word_out.sol  = out_sol & enable;
        word_out.eol  = out_eol & enable;
        word_out.data = out_data;
    end

endmodule

/* pulse_cross_clock.sv */
`timescale 1ns/1ps

module pulse_cross_clock (
    input  logic rst,                            // src_clk domain reset
    input  logic src_clk,
    input  logic dst_clk,
    input  logic in_pulse,                       // single src cycle
    output logic out_pulse,                      // single dst cycle
    output logic busy                            // crossing still in flight
);

    logic       src_tgl;                         // flips once per pulse
    logic [2:0] dst_sync;                        // two sync flops plus edge stage
    logic [1:0] ack_sync;                        // dst toggle back in src

    always_ff @(posedge src_clk) begin
        if (rst) begin
            src_tgl  <= 1'b0;
            ack_sync <= '0;
        end else begin
            if (in_pulse)
                src_tgl <= ~src_tgl;
            ack_sync <= {ack_sync[0], dst_sync[1]};
        end
    end

    // reset held over several src cycles, long enough for dst to see it
    always_ff @(posedge dst_clk) begin
        if (rst)
            dst_sync <= '0;
        else
            dst_sync <= {dst_sync[1:0], src_tgl};
    end

    assign out_pulse = dst_sync[2] ^ dst_sync[1];   // edge detect
    assign busy      = src_tgl ^ ack_sync[1];       // until dst has it

endmodule

/* sens_hispi_fifo.sv */
`timescale 1ns/1ps

module sens_hispi_fifo #(
    parameter int  COUNT_START = 7,              // writes before read may start
    parameter int  FIFO_DEPTH  = 4,              // log2 of words
    parameter type data_t      = logic [11:0]
) (
    input  logic  ipclk,
    input  logic  prst,
    input  logic  we,
    input  logic  sol,                           // at least 1 cycle before first we
    input  logic  eol,                           // with last we
    input  data_t din,
    input  logic  pclk,
    input  logic  re,
    output data_t dout,                          // valid cycle after re
    output logic  run                            // drops 1 cycle after emptying read
);

    localparam int WORDS = 1 << FIFO_DEPTH;

    data_t               fifo_ram [WORDS];
    logic [FIFO_DEPTH:0] wa;                     // extra bit, full line fits
    logic [FIFO_DEPTH:0] ra;
    logic                line_run_ipclk;         // between sol and eol
    logic                line_start_ipclk;
    logic                line_start_pclk;
    logic [1:0]          line_run_sync;
    logic                line_run_pclk;
    logic [1:0]          prst_sync;
    logic                prst_pclk;
    logic                run_r;

    assign line_start_ipclk = we && line_run_ipclk &&
                              (wa == (FIFO_DEPTH+1)'(COUNT_START));   // 8th write
    assign prst_pclk        = prst_sync[1];
    assign run              = run_r;

    // write side
    always_ff @(posedge ipclk) begin
        if (prst || sol)
            wa <= '0;
        else if (we && line_run_ipclk)
            wa <= wa + 1'b1;

        if (prst || eol)
            line_run_ipclk <= 1'b0;
        else if (sol)
            line_run_ipclk <= 1'b1;
    end

    always_ff @(posedge ipclk) begin
        if (we && line_run_ipclk)
            fifo_ram[wa[FIFO_DEPTH-1:0]] <= din;
    end

    // reset into pclk
    always_ff @(posedge pclk) begin
        prst_sync <= {prst_sync[0], prst};
    end

    // read side; wa is only compared once the line has stopped writing
    always_ff @(posedge pclk) begin
        if (prst_pclk) begin
            line_run_sync <= '0;
            line_run_pclk <= 1'b0;
            run_r         <= 1'b0;
            ra            <= '0;
        end else begin
            line_run_sync <= {line_run_sync[0], line_run_ipclk};
            line_run_pclk <= line_run_sync[1] && (line_run_pclk || line_start_pclk);

            if (line_start_pclk)
                run_r <= 1'b1;
            else if (!line_run_pclk && (ra == wa))
                run_r <= 1'b0;                   // line over and drained

            if (line_start_pclk)
                ra <= '0;
            else if (re)
                ra <= ra + 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (re)
            dout <= fifo_ram[ra[FIFO_DEPTH-1:0]];
    end

    pulse_cross_clock u_line_start (
        .rst       (prst),
        .src_clk   (ipclk),
        .dst_clk   (pclk),
        .in_pulse  (line_start_ipclk),
        .out_pulse (line_start_pclk),
        .busy      ()
    );

endmodule

/* tb_hispi_lane_rx.sv */
`timescale 1ns/1ps

module tb_hispi_lane_rx;

    localparam int COUNT_START = 7;
    localparam int FIFO_DEPTH  = 4;
    localparam int SYNC_WORDS  = 8;                   // start and end sequence
    localparam int RAND_LINES  = 20;
    localparam int TOTAL_WORDS = 4 * SYNC_WORDS + 12 + 5 + 12 + 10
                               + RAND_LINES * (16 + SYNC_WORDS);   // worst case
    localparam int WATCHDOG_NS = TOTAL_WORDS * 400 * 4;

    logic                 ipclk;
    logic                 pclk;
    logic                 prst;
    logic                 rx_valid;
    logic                 cfg_we;
    logic                 re;
    logic                 run;
    hispi_pkg::pixel_t    rx_word;
    hispi_pkg::pixel_t    dout;
    hispi_pkg::reg_addr_t cfg_addr;
    hispi_pkg::reg_data_t cfg_wdata;
    hispi_pkg::reg_data_t cfg_rdata;

    hispi_pkg::pixel_t line_q[$];                     // payload of the line in flight
    logic [31:0]       rng;
    logic              lane_on;                       // model of the enable bit
    int                exp_lines;
    int                exp_short;
    int                err_count;
    int                check_count;
    int                test_count;

    hispi_lane_rx #(
        .COUNT_START (COUNT_START),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_dut (
        .ipclk     (ipclk),
        .prst      (prst),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .pclk      (pclk),
        .re        (re),
        .dout      (dout),
        .run       (run)
    );

    initial begin
        ipclk = 1'b0;
        forever #50 ipclk = ~ipclk;                   // 100 ns
    end

    initial begin
        pclk = 1'b0;
        forever #65 pclk = ~pclk;                     // 130 ns, slower than ipclk
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);                      // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            $display("error %s: expected %0h, actual %0h", test, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_true(input logic ok, input string test, input string what);
        check_count++;
        assert (ok) else begin
            $display("%s: %s", test, what);
            err_count++;
        end
    endtask

    task automatic reg_write(input hispi_pkg::reg_addr_t addr, input hispi_pkg::reg_data_t data);
        @(negedge ipclk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge ipclk);
        cfg_we    = 1'b0;
    endtask

    task automatic reg_check(input string test, input hispi_pkg::reg_addr_t addr, input int exp);
        @(negedge ipclk);
        cfg_addr = addr;
        #10;                                          // rdata is combinational
        check_value(test, exp, int'(cfg_rdata));
    endtask

    task automatic set_enable(input logic on);
        reg_write(hispi_pkg::REG_CTRL, {15'd0, on});
        lane_on = on;
    endtask

    task automatic make_line(input int n, input logic rnd);
        line_q.delete();
        for (int i = 0; i < n; i++) begin
            if (rnd)
                line_q.push_back(hispi_pkg::pixel_t'(next_random() % 32'd4095));  // no FFF
            else
                line_q.push_back(12'h0A0 + 12'(i));   // ramp
        end
    endtask

    task automatic send_word(input hispi_pkg::pixel_t w);
        @(negedge ipclk);
        rx_word  = w;
        rx_valid = 1'b1;
    endtask

    task automatic send_sync(input hispi_pkg::pixel_t code);
        send_word(hispi_pkg::SYNC_PREFIX);
        send_word(12'h000);
        send_word(12'h000);
        send_word(code);
    endtask

    // words go out back to back, the decoder pipe needs that
    task automatic send_line(input hispi_pkg::pixel_t sc, input hispi_pkg::pixel_t ec);
        send_sync(sc);
        foreach (line_q[i]) send_word(line_q[i]);
        send_sync(ec);
        @(negedge ipclk);
        rx_valid = 1'b0;
        rx_word  = '0;
        repeat (3) @(negedge ipclk);                  // eol out of decoder
        if (lane_on) begin
            exp_lines++;
            if (line_q.size() <= COUNT_START)
                exp_short++;                          // run never starts
        end
    endtask

    task automatic read_line(input string test);
        int n;
        int waited;
        n = line_q.size();
        waited = 0;
        while (!run && waited < 100) begin
            @(negedge pclk);
            waited++;
        end
        check_true(run, test, "run never rose for a full line");
        if (!run)
            return;
        for (int i = 0; i <= n; i++) begin            // dout one cycle behind re
            @(negedge pclk);
            if (i > 0)
                check_value(test, line_q[i-1], dout);
            re = (i < n);
        end
        repeat (2) begin
            if (run)
                @(negedge pclk);
        end
        check_true(!run, test, "run still high 2 pclk cycles after the last read");
    endtask

    task automatic expect_run_low(input string test, input int cycles);
        logic seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge pclk);
            if (run)
                seen = 1'b1;
        end
        check_true(!seen, test, "run rose for a line that must not start");
    endtask

    task automatic report(input string test, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("test %s done, no errors", test);
        else
            $display("test %s done, %0d errors", test, err_count - errs_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_count;
        check_true(!run, "reset", "run is high after reset");
        reg_check("reset", hispi_pkg::REG_CTRL, 0);
        reg_check("reset", hispi_pkg::REG_LINES, 0);
        reg_check("reset", hispi_pkg::REG_SHORT, 0);
        report("reset", e0);
    endtask

    task automatic test_single_line();
        int e0;
        e0 = err_count;
        set_enable(1'b1);
        reg_check("single_line", hispi_pkg::REG_CTRL, 1);
        make_line(12, 1'b0);
        send_line(hispi_pkg::CODE_SOL, hispi_pkg::CODE_EOL);
        read_line("single_line");
        reg_check("single_line", hispi_pkg::REG_LINES, 1);
        report("single_line", e0);
    endtask

    task automatic test_random_lines();
        int                e0;
        logic [31:0]       r;
        hispi_pkg::pixel_t sc;
        hispi_pkg::pixel_t ec;
        e0 = err_count;
        for (int i = 0; i < RAND_LINES; i++) begin
            r  = next_random();
            sc = r[0] ? hispi_pkg::CODE_SOF : hispi_pkg::CODE_SOL;   // both open a line
            ec = r[1] ? hispi_pkg::CODE_EOF : hispi_pkg::CODE_EOL;
            make_line(8 + int'(next_random() % 32'd9), 1'b1);        // 8 to 16 words
            send_line(sc, ec);
            read_line("random_lines");
        end
        reg_check("random_lines", hispi_pkg::REG_LINES, exp_lines);
        reg_check("random_lines", hispi_pkg::REG_SHORT, exp_short);
        report("random_lines", e0);
    endtask

    task automatic test_short_line();
        int e0;
        e0 = err_count;
        make_line(5, 1'b1);
        fork
            send_line(hispi_pkg::CODE_SOL, hispi_pkg::CODE_EOL);
            expect_run_low("short_line", 60);         // send time plus 40 pclk
        join
        reg_check("short_line", hispi_pkg::REG_LINES, exp_lines);
        reg_check("short_line", hispi_pkg::REG_SHORT, exp_short);
        report("short_line", e0);
    endtask

    task automatic test_disabled();
        int e0;
        e0 = err_count;
        set_enable(1'b0);
        reg_check("disabled", hispi_pkg::REG_CTRL, 0);
        make_line(12, 1'b1);
        fork
            send_line(hispi_pkg::CODE_SOL, hispi_pkg::CODE_EOL);
            expect_run_low("disabled", 60);
        join
        reg_check("disabled", hispi_pkg::REG_LINES, exp_lines);   // unchanged
        reg_check("disabled", hispi_pkg::REG_SHORT, exp_short);
        set_enable(1'b1);
        report("disabled", e0);
    endtask

    task automatic test_counter_clear();
        int e0;
        e0 = err_count;
        reg_write(hispi_pkg::REG_LINES, 16'hFFFF);    // any write clears
        reg_write(hispi_pkg::REG_SHORT, 16'h5A5A);
        exp_lines = 0;
        exp_short = 0;
        reg_check("counter_clear", hispi_pkg::REG_LINES, 0);
        reg_check("counter_clear", hispi_pkg::REG_SHORT, 0);
        make_line(10, 1'b1);
        send_line(hispi_pkg::CODE_SOF, hispi_pkg::CODE_EOF);
        read_line("counter_clear");
        reg_check("counter_clear", hispi_pkg::REG_LINES, 1);
        reg_check("counter_clear", hispi_pkg::REG_SHORT, 0);
        report("counter_clear", e0);
    endtask

    initial begin
        prst        = 1'b1;
        rx_word     = '0;
        rx_valid    = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        re          = 1'b0;
        rng         = 32'h70096ed2;
        lane_on     = 1'b0;
        exp_lines   = 0;
        exp_short   = 0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        repeat (2) @(posedge ipclk);
        @(negedge ipclk);
        prst = 1'b0;
        repeat (4) @(negedge ipclk);                  // pclk side out of reset
        test_reset();
        test_single_line();
        test_random_lines();
        test_short_line();
        test_disabled();
        test_counter_clear();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, err_count, u_dut.u_sva.fail_cnt);
        if (err_count == 0 && u_dut.u_sva.fail_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
hispi_pkg.sv
pulse_cross_clock.sv
hispi_sync_decoder.sv
hispi_lane_regs.sv
sens_hispi_fifo.sv
hispi_lane_rx.sv
hispi_lane_rx_sva.sv
tb_hispi_lane_rx.sv
